//--- logic/bumpy_pkg.sv
package bumpy_pkg;

	localparam int FIXED_POINT_SHIFT = 6; // 64 sub-pixels per pixel
	localparam int TILE_PIXELS = 64;
	localparam int BUMPY_PIXELS = 16;
	localparam int EDGE_MARGIN = 10; // sub-pixels
	localparam int BOARD_TILES = 8; // tiles per row and per column

	localparam int IDX_BITS = $clog2(BOARD_TILES); // bits of a row or column index
	localparam int TILE_SHIFT = $clog2(TILE_PIXELS) + FIXED_POINT_SHIFT;
	localparam int TILE_FIX = TILE_PIXELS << FIXED_POINT_SHIFT; // tile side in sub-pixels
	localparam int BUMPY_FIX = BUMPY_PIXELS << FIXED_POINT_SHIFT;

	typedef logic signed [10:0] coord_t; // screen pixel
	typedef logic signed [17:0] fixpos_t; // 1/64 pixel
	typedef logic signed [7:0] speed_t; // 1/64 pixel per frame
	typedef logic [5:0] tile_addr_t; // row * 8 + column

	typedef enum logic [1:0] {
		tile_floor,
		tile_wall,
		tile_hole
	} tile_kind_t;

	typedef enum logic [3:0] {
		s_reset,
		s_idle,
		s_left,
		s_right,
		s_down,
		s_up,
		s_die,
		s_bounce_left,
		s_bounce_right,
		s_bounce_top
	} move_state_t;

	// origin of the tile that holds bumpy's centre
	function automatic fixpos_t tile_origin(input fixpos_t p);
		fixpos_t centre;
		centre = p + fixpos_t'(BUMPY_FIX / 2);
		return centre & ~fixpos_t'(TILE_FIX - 1); // floor to a tile boundary
	endfunction

endpackage

//--- logic/tile_map.sv
module tile_map import bumpy_pkg::*; (
	input logic clk,
	input logic we, // host load strobe
	input tile_addr_t waddr,
	input tile_kind_t wdata,
	input tile_addr_t raddr, // from the arbiter
	output tile_kind_t rdata
);

	tile_kind_t mem [BOARD_TILES * BOARD_TILES];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
		// registered read, a colliding write wins
		if (we && waddr == raddr)
			rdata <= wdata;
		else
			rdata <= mem[raddr];
	end

endmodule

//--- logic/map_arbiter.sv
module map_arbiter import bumpy_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic req_probe, // collision probe
	input logic req_video, // pixel lookup
	input tile_addr_t raddr_probe,
	input tile_addr_t raddr_video,
	output logic gnt_probe,
	output logic gnt_video,
	output tile_addr_t mem_raddr
);

	logic last_video; // video peer had the previous grant

	// on a tie the peer granted last steps back one cycle
	assign gnt_probe = req_probe && (!req_video || last_video);
	assign gnt_video = req_video && (!req_probe || !last_video);

	// idle cycles present the probe address, harmless
	assign mem_raddr = gnt_video ? raddr_video : raddr_probe;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			last_video <= 1'b1; // probe wins the first tie
		end else begin
			if (gnt_video)
				last_video <= 1'b1;
			else if (gnt_probe)
				last_video <= 1'b0;
		end
	end

endmodule

//--- logic/tile_probe.sv
module tile_probe import bumpy_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input fixpos_t pos_x,
	input fixpos_t pos_y,
	output logic req,
	output tile_addr_t raddr,
	input logic gnt,
	input tile_kind_t rdata,
	output logic probe_done,
	output logic wall_left,
	output logic wall_right,
	output logic wall_top,
	output logic on_hole
);

	typedef enum logic [2:0] {p_idle, p_latch, p_read, p_capture, p_done} probe_state_t;

	probe_state_t pstate;
	logic [1:0] step; // 0 current, 1 side, 2 top
	fixpos_t lat_x, lat_y; // position seen this frame
	fixpos_t org_x, org_y; // tile origin under bumpy's centre
	fixpos_t ofs_x, ofs_y; // top left inside that tile, may dip below 0
	logic [IDX_BITS-1:0] col, row;
	logic right_half; // side read goes to the right neighbour
	logic side_off, top_off; // neighbour is beyond the board
	logic side_wall;
	tile_kind_t kind_cur, kind_side, kind_top;

	assign org_x = tile_origin(lat_x);
	assign org_y = tile_origin(lat_y);
	assign ofs_x = lat_x - org_x;
	assign ofs_y = lat_y - org_y;
	assign col = org_x[TILE_SHIFT +: IDX_BITS];
	assign row = org_y[TILE_SHIFT +: IDX_BITS];
	assign right_half = ofs_x > (TILE_FIX - BUMPY_FIX) / 2;

	assign side_off = right_half ? (col == IDX_BITS'(BOARD_TILES - 1)) : (col == '0);
	assign top_off = (row == '0);

	always_comb begin
		case (step)
			2'd0: raddr = {row, col};
			2'd1: raddr = right_half ? {row, col + 1'b1} : {row, col - 1'b1};
			default: raddr = {row - 1'b1, col}; // wraps off board, overridden below
		endcase
	end

	assign req = (pstate == p_read); // held until the grant
	assign probe_done = (pstate == p_done);

	// flags settle with probe_done
	assign side_wall = side_off || kind_side == tile_wall;
	assign on_hole = (kind_cur == tile_hole);
	assign wall_left = !right_half && side_wall && ofs_x < EDGE_MARGIN;
	assign wall_right = right_half && side_wall && ofs_x > TILE_FIX - BUMPY_FIX - EDGE_MARGIN;
	assign wall_top = (top_off || kind_top == tile_wall) && ofs_y < EDGE_MARGIN;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pstate <= p_idle;
			step <= '0;
		end else begin
			case (pstate)
				p_idle: if (start_of_frame) pstate <= p_latch;
				p_latch: begin // position has just integrated
					step <= '0;
					pstate <= p_read;
				end
				p_read: if (gnt) pstate <= p_capture;
				p_capture: begin // rdata belongs to the last grant
					if (step == 2'd2) begin
						pstate <= p_done;
					end else begin
						step <= step + 1'b1;
						pstate <= p_read;
					end
				end
				p_done: pstate <= p_idle;
				default: pstate <= p_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pstate == p_latch) begin
			lat_x <= pos_x;
			lat_y <= pos_y;
		end
		if (pstate == p_capture) begin
			case (step)
				2'd0: kind_cur <= rdata;
				2'd1: kind_side <= rdata;
				default: kind_top <= rdata;
			endcase
		end
	end

endmodule

//--- logic/pixel_tile_fetch.sv
module pixel_tile_fetch import bumpy_pkg::*; (
	input logic clk,
	input logic resetN,
	input coord_t pixel_x,
	input coord_t pixel_y,
	output logic req,
	output tile_addr_t raddr,
	input logic gnt,
	input tile_kind_t rdata,
	output tile_kind_t pixel_tile,
	output logic pixel_tile_valid
);

	localparam int PIX_SHIFT = $clog2(TILE_PIXELS);
	localparam int BOARD_PIXELS = BOARD_TILES * TILE_PIXELS;

	logic in_board;
	tile_addr_t pix_addr; // tile under the current pixel
	logic have_last; // a lookup was made since reset
	logic last_in;
	tile_addr_t last_addr;
	logic wait_data; // cycle after our grant
	logic valid_q;
	tile_kind_t tile_q;
	logic busy;
	logic changed;

	assign in_board = pixel_x >= 0 && pixel_x < BOARD_PIXELS
		&& pixel_y >= 0 && pixel_y < BOARD_PIXELS;
	assign pix_addr = {pixel_y[PIX_SHIFT +: IDX_BITS], pixel_x[PIX_SHIFT +: IDX_BITS]};
	assign changed = !have_last || in_board != last_in || (in_board && pix_addr != last_addr);
	assign busy = req || wait_data; // new tiles wait, raddr must stay put
	assign raddr = last_addr;

	// fresh data shows in the cycle after the grant
	assign pixel_tile = wait_data ? rdata : tile_q;
	assign pixel_tile_valid = wait_data || valid_q;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			req <= 1'b0;
			wait_data <= 1'b0;
			valid_q <= 1'b0;
			have_last <= 1'b0;
			last_in <= 1'b0;
			last_addr <= '0;
		end else begin
			wait_data <= req && gnt;
			if (req && gnt)
				req <= 1'b0;
			if (wait_data)
				valid_q <= 1'b1;
			if (changed && !busy) begin
				have_last <= 1'b1;
				last_in <= in_board;
				last_addr <= pix_addr;
				req <= in_board; // off board needs no read
				valid_q <= !in_board;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wait_data)
			tile_q <= rdata;
		else if (changed && !busy && !in_board)
			tile_q <= tile_wall; // outside the board reads as wall
	end

endmodule

//--- logic/bumpy_control.sv
module bumpy_control import bumpy_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic key_left,
	input logic key_right,
	input logic key_up,
	input logic key_down,
	input logic probe_done,
	input logic wall_left,
	input logic wall_right,
	input logic wall_top,
	input logic on_hole,
	output move_state_t state,
	output logic dead
);

	move_state_t key_state; // motion the keys ask for
	move_state_t next_state;

	always_comb begin
		if (key_left)
			key_state = s_left;
		else if (key_right)
			key_state = s_right;
		else if (key_up)
			key_state = s_up;
		else if (key_down)
			key_state = s_down;
		else
			key_state = s_idle;
	end

	// hole beats wall, wall beats keys
	always_comb begin
		next_state = key_state;
		if (on_hole)
			next_state = s_die;
		else if (key_state == s_left && wall_left)
			next_state = s_bounce_left;
		else if (key_state == s_right && wall_right)
			next_state = s_bounce_right;
		else if (key_state == s_up && wall_top)
			next_state = s_bounce_top;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= s_reset;
		end else begin
			if (state == s_reset)
				state <= s_idle;
			else if (state != s_die && probe_done) // die holds until reset
				state <= next_state;
		end
	end

	assign dead = (state == s_die);

endmodule

//--- logic/bumpy_move.sv
module bumpy_move import bumpy_pkg::*; #(
	parameter int SPEED = 20, // sub-pixels per frame
	parameter int START_COL = 3,
	parameter int START_ROW = 3
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame,
	input move_state_t state,
	output fixpos_t pos_x,
	output fixpos_t pos_y,
	output coord_t offset_topleft_x,
	output coord_t offset_topleft_y
);

	// start centred in the chosen tile
	localparam int CENTRE_OFS = (TILE_FIX - BUMPY_FIX) / 2;
	localparam fixpos_t START_X = fixpos_t'(START_COL * TILE_FIX + CENTRE_OFS);
	localparam fixpos_t START_Y = fixpos_t'(START_ROW * TILE_FIX + CENTRE_OFS);
	localparam speed_t SPEED_P = speed_t'(SPEED);
	localparam speed_t SPEED_N = speed_t'(-SPEED);
	localparam int LOW_LIMIT = EDGE_MARGIN; // bob turns down here
	localparam int HIGH_LIMIT = TILE_FIX - BUMPY_FIX - EDGE_MARGIN; // and up here

	speed_t speed_x, speed_y;
	fixpos_t ofs_y; // height inside the current tile

	assign ofs_y = pos_y - tile_origin(pos_y);

	// y speed
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speed_y <= '0;
		end else begin
			case (state)
				s_reset, s_die: speed_y <= '0;
				s_idle, s_left, s_right, s_bounce_left, s_bounce_right: begin
					if (speed_y == 0)
						speed_y <= SPEED_P; // start bobbing downwards
					if (ofs_y > HIGH_LIMIT && speed_y >= 0)
						speed_y <= SPEED_N;
					if (ofs_y < LOW_LIMIT && speed_y <= 0)
						speed_y <= SPEED_P;
				end
				s_down: speed_y <= SPEED_P;
				s_up: speed_y <= SPEED_N;
				s_bounce_top: speed_y <= SPEED_P; // away from the wall above
				default: speed_y <= '0;
			endcase
		end
	end

	// x speed
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speed_x <= '0;
		end else begin
			case (state)
				s_left: speed_x <= SPEED_N;
				s_right: speed_x <= SPEED_P;
				s_bounce_left: speed_x <= SPEED_P; // reversed, pushes off the left wall
				s_bounce_right: speed_x <= SPEED_N;
				default: speed_x <= '0; // reset, idle, up, down, top bounce, die
			endcase
		end
	end

	// integrate once per frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos_x <= START_X;
			pos_y <= START_Y;
		end else if (start_of_frame) begin
			pos_x <= pos_x + speed_x;
			pos_y <= pos_y + speed_y;
		end
	end

	// drop the sub-pixel bits
	assign offset_topleft_x = coord_t'(pos_x >>> FIXED_POINT_SHIFT);
	assign offset_topleft_y = coord_t'(pos_y >>> FIXED_POINT_SHIFT);

endmodule

//--- logic/bumpy_top.sv
module bumpy_top import bumpy_pkg::*; #(
	parameter int SPEED = 20,
	parameter int START_COL = 3,
	parameter int START_ROW = 3
) (
	input logic clk,
	input logic resetN,
	input logic start_of_frame, // one cycle per frame
	input logic key_left,
	input logic key_right,
	input logic key_up,
	input logic key_down,
	input logic map_we,
	input tile_addr_t map_waddr,
	input tile_kind_t map_wdata,
	input coord_t pixel_x,
	input coord_t pixel_y,
	output coord_t offset_topleft_x,
	output coord_t offset_topleft_y,
	output tile_kind_t pixel_tile,
	output logic pixel_tile_valid,
	output logic dead
);

	logic req_probe, req_video;
	logic gnt_probe, gnt_video;
	tile_addr_t raddr_probe, raddr_video, mem_raddr;
	tile_kind_t rdata; // shared by both peers
	logic probe_done, wall_left, wall_right, wall_top, on_hole;
	move_state_t state;
	fixpos_t pos_x, pos_y;

	tile_map u_map (
		.clk(clk),
		.we(map_we),
		.waddr(map_waddr),
		.wdata(map_wdata),
		.raddr(mem_raddr),
		.rdata(rdata)
	);

	map_arbiter u_arb (
		.clk(clk),
		.resetN(resetN),
		.req_probe(req_probe),
		.req_video(req_video),
		.raddr_probe(raddr_probe),
		.raddr_video(raddr_video),
		.gnt_probe(gnt_probe),
		.gnt_video(gnt_video),
		.mem_raddr(mem_raddr)
	);

	tile_probe u_probe (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.req(req_probe),
		.raddr(raddr_probe),
		.gnt(gnt_probe),
		.rdata(rdata),
		.probe_done(probe_done),
		.wall_left(wall_left),
		.wall_right(wall_right),
		.wall_top(wall_top),
		.on_hole(on_hole)
	);

	pixel_tile_fetch u_fetch (
		.clk(clk),
		.resetN(resetN),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.req(req_video),
		.raddr(raddr_video),
		.gnt(gnt_video),
		.rdata(rdata),
		.pixel_tile(pixel_tile),
		.pixel_tile_valid(pixel_tile_valid)
	);

	bumpy_control u_ctrl (
		.clk(clk),
		.resetN(resetN),
		.key_left(key_left),
		.key_right(key_right),
		.key_up(key_up),
		.key_down(key_down),
		.probe_done(probe_done),
		.wall_left(wall_left),
		.wall_right(wall_right),
		.wall_top(wall_top),
		.on_hole(on_hole),
		.state(state),
		.dead(dead)
	);

	bumpy_move #(
		.SPEED(SPEED),
		.START_COL(START_COL),
		.START_ROW(START_ROW)
	) u_move (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.state(state),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.offset_topleft_x(offset_topleft_x),
		.offset_topleft_y(offset_topleft_y)
	);

endmodule

//--- tb/bumpy_checker.sv
module bumpy_checker (
	input logic clk,
	input logic resetN,
	input logic req_probe,
	input logic req_video,
	input logic gnt_probe,
	input logic gnt_video,
	input logic dead
);

	timeunit 1ns;
	timeprecision 100ps;

	int fails = 0; // read by the testbench at the end

	// one map read per cycle
	a_one_grant: assert property (@(posedge clk) disable iff (!resetN)
		!(gnt_probe && gnt_video))
		else begin
			$error("probe and video granted in the same cycle");
			fails++;
		end

	a_probe_gnt_req: assert property (@(posedge clk) disable iff (!resetN)
		gnt_probe |-> req_probe)
		else begin
			$error("probe granted without a request");
			fails++;
		end

	a_video_gnt_req: assert property (@(posedge clk) disable iff (!resetN)
		gnt_video |-> req_video)
		else begin
			$error("video granted without a request");
			fails++;
		end

	// die is terminal until reset
	a_dead_sticky: assert property (@(posedge clk) disable iff (!resetN)
		dead |=> dead)
		else begin
			$error("dead dropped without a reset");
			fails++;
		end

endmodule

// arbiter side, no dead signal there
bind map_arbiter bumpy_checker u_chk_arb (
	.clk(clk),
	.resetN(resetN),
	.req_probe(req_probe),
	.req_video(req_video),
	.gnt_probe(gnt_probe),
	.gnt_video(gnt_video),
	.dead(1'b0)
);

// control side, map port tied quiet
bind bumpy_control bumpy_checker u_chk_ctrl (
	.clk(clk),
	.resetN(resetN),
	.req_probe(1'b0),
	.req_video(1'b0),
	.gnt_probe(1'b0),
	.gnt_video(1'b0),
	.dead(dead)
);

//--- tb/bumpy_tb.sv
module bumpy_tb import bumpy_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SPEED = 20;
	localparam int START_COL = 3;
	localparam int START_ROW = 3;
	localparam int CLK_PERIOD = 100; // ns
	localparam int FRAME_CYCLES = 40;
	localparam int ROW_MARGIN = 500 * CLK_PERIOD; // reset, map load, lookups
	localparam int LOOKUP_WAIT = 20; // cycles
	localparam int START_X = (START_COL * TILE_PIXELS + (TILE_PIXELS - BUMPY_PIXELS) / 2)
		<< FIXED_POINT_SHIFT;
	localparam int START_Y = (START_ROW * TILE_PIXELS + (TILE_PIXELS - BUMPY_PIXELS) / 2)
		<< FIXED_POINT_SHIFT;

	localparam logic [3:0] K_NONE = 4'b0000; // {left, right, up, down}
	localparam logic [3:0] K_LEFT = 4'b1000;

	localparam int CHK_Y_TILE = 1; // y inside the start tile every frame
	localparam int CHK_X_FLOOR = 2; // x not past the left wall
	localparam int CHK_FROZEN = 4; // dead after frame 1, offsets hold
	localparam int CHK_BOB = 8; // y moves both ways

	typedef struct {
		string name;
		bit lookup; // pixel lookup row instead of motion
		bit pattern_map;
		int sp_addr; // one tile set apart, -1 for none
		tile_kind_t sp_kind;
		logic [3:0] keys;
		int frames;
		int checks;
		coord_t exp_x;
		coord_t exp_y;
		logic exp_dead;
	} row_t;

	logic clk;
	logic resetN;
	logic start_of_frame;
	logic key_left, key_right, key_up, key_down;
	logic map_we;
	tile_addr_t map_waddr;
	tile_kind_t map_wdata;
	coord_t pixel_x, pixel_y;
	coord_t offset_topleft_x, offset_topleft_y;
	tile_kind_t pixel_tile;
	logic pixel_tile_valid;
	logic dead;

	row_t rows[$];
	tile_kind_t model_map [BOARD_TILES * BOARD_TILES];
	logic [31:0] rng_state = 32'hf424_7b58;
	int errors = 0;
	int checks = 0;

	bumpy_top #(
		.SPEED(SPEED),
		.START_COL(START_COL),
		.START_ROW(START_ROW)
	) uut (
		.clk(clk),
		.resetN(resetN),
		.start_of_frame(start_of_frame),
		.key_left(key_left),
		.key_right(key_right),
		.key_up(key_up),
		.key_down(key_down),
		.map_we(map_we),
		.map_waddr(map_waddr),
		.map_wdata(map_wdata),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.offset_topleft_x(offset_topleft_x),
		.offset_topleft_y(offset_topleft_y),
		.pixel_tile(pixel_tile),
		.pixel_tile_valid(pixel_tile_valid),
		.dead(dead)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// tile index of the tile holding bumpy's centre, one axis
	function automatic int centre_tile(int p);
		return (p + (BUMPY_PIXELS << FIXED_POINT_SHIFT) / 2) / (TILE_PIXELS << FIXED_POINT_SHIFT);
	endfunction

	function automatic int speed_x_of(move_state_t s);
		case (s)
			s_left, s_bounce_right: return -SPEED;
			s_right, s_bounce_left: return SPEED;
			default: return 0;
		endcase
	endfunction

	// bob reverses near top and bottom limits of the tile
	function automatic int speed_y_of(move_state_t s, int vy, int py);
		int ofs;
		ofs = py - centre_tile(py) * (TILE_PIXELS << FIXED_POINT_SHIFT);
		case (s)
			s_down, s_bounce_top: return SPEED;
			s_up: return -SPEED;
			s_idle, s_left, s_right, s_bounce_left, s_bounce_right: begin
				if (ofs > ((TILE_PIXELS - BUMPY_PIXELS) << FIXED_POINT_SHIFT) - EDGE_MARGIN
						&& vy >= 0)
					return -SPEED;
				if (ofs < EDGE_MARGIN && vy <= 0)
					return SPEED;
				return (vy == 0) ? SPEED : vy;
			end
			default: return 0;
		endcase
	endfunction

	// state chosen at the end of a frame's probe
	function automatic move_state_t state_after(move_state_t s, logic [3:0] keys,
			int px, int py);
		int col, row, ofs_x, ofs_y, side, tile_fix;
		bit right_half, side_wall, top_wall;
		tile_fix = TILE_PIXELS << FIXED_POINT_SHIFT;
		col = centre_tile(px);
		row = centre_tile(py);
		ofs_x = px - col * tile_fix;
		ofs_y = py - row * tile_fix;
		right_half = ofs_x > ((TILE_PIXELS - BUMPY_PIXELS) << FIXED_POINT_SHIFT) / 2;
		side = right_half ? col + 1 : col - 1;
		side_wall = side < 0 || side >= BOARD_TILES
			|| model_map[row * BOARD_TILES + side] == tile_wall; // off board is wall
		top_wall = row == 0 || model_map[(row - 1) * BOARD_TILES + col] == tile_wall;
		if (s == s_die || model_map[row * BOARD_TILES + col] == tile_hole)
			return s_die;
		if (keys[3])
			return (!right_half && side_wall && ofs_x < EDGE_MARGIN) ? s_bounce_left : s_left;
		if (keys[2])
			return (right_half && side_wall
				&& ofs_x > tile_fix - (BUMPY_PIXELS << FIXED_POINT_SHIFT) - EDGE_MARGIN)
				? s_bounce_right : s_right;
		if (keys[1])
			return (top_wall && ofs_y < EDGE_MARGIN) ? s_bounce_top : s_up;
		if (keys[0])
			return s_down;
		return s_idle;
	endfunction

	task automatic build_map(input row_t rw);
		for (int a = 0; a < BOARD_TILES * BOARD_TILES; a++) begin
			if (rw.pattern_map)
				model_map[a] = tile_kind_t'((a + a / BOARD_TILES) % 3); // row and column mix
			else
				model_map[a] = tile_floor;
		end
		if (rw.sp_addr >= 0)
			model_map[rw.sp_addr] = rw.sp_kind;
	endtask

	// frame level reference, fills the row's expected results
	task automatic predict_row(inout row_t rw);
		int px, py, vx, vy;
		move_state_t s;
		build_map(rw);
		px = START_X;
		py = START_Y;
		s = s_idle;
		vx = 0;
		vy = speed_y_of(s_idle, 0, py);
		for (int f = 0; f < rw.frames; f++) begin
			px += vx; // integrate on the frame pulse
			py += vy;
			vy = speed_y_of(s, vy, py); // old state sees the new position first
			s = state_after(s, rw.keys, px, py);
			vx = speed_x_of(s);
			vy = speed_y_of(s, vy, py);
		end
		rw.exp_x = coord_t'(px >>> FIXED_POINT_SHIFT);
		rw.exp_y = coord_t'(py >>> FIXED_POINT_SHIFT);
		rw.exp_dead = (s == s_die);
	endtask

	task automatic add_row(input string name, input bit lookup, input bit pattern,
			input int sp_addr, input tile_kind_t sp_kind, input logic [3:0] keys,
			input int frames, input int chk);
		row_t rw;
		rw.name = name;
		rw.lookup = lookup;
		rw.pattern_map = pattern;
		rw.sp_addr = sp_addr;
		rw.sp_kind = sp_kind;
		rw.keys = keys;
		rw.frames = frames;
		rw.checks = chk;
		predict_row(rw);
		rows.push_back(rw);
	endtask

	task automatic check_coord(input string what, input coord_t got, input coord_t want);
		checks++;
		if (got !== want) begin
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic check_coord_range(input string what, input coord_t got,
			input coord_t lo, input coord_t hi);
		checks++;
		if (got < lo || got > hi) begin
			$display("ERR %0t: %s is %0d, outside %0d..%0d", $time, what, got, lo, hi);
			errors++;
		end
	endtask

	task automatic check_kind(input string what, input tile_kind_t got, input tile_kind_t want);
		checks++;
		if (got !== want) begin
			$display("ERR %0t: %s is %s, expected %s", $time, what, got.name(), want.name());
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		resetN <= 1'b0;
		start_of_frame <= 1'b0;
		{key_left, key_right, key_up, key_down} <= K_NONE;
		repeat (4) @(posedge clk);
		resetN <= 1'b1;
	endtask

	task automatic load_map();
		for (int a = 0; a < BOARD_TILES * BOARD_TILES; a++) begin
			@(posedge clk);
			map_we <= 1'b1;
			map_waddr <= tile_addr_t'(a);
			map_wdata <= model_map[a];
		end
		@(posedge clk);
		map_we <= 1'b0;
	endtask

	task automatic run_frame();
		@(posedge clk);
		start_of_frame <= 1'b1;
		@(posedge clk);
		start_of_frame <= 1'b0;
		repeat (FRAME_CYCLES - 2) @(posedge clk);
		@(negedge clk); // outputs settled mid cycle
	endtask

	task automatic lookup_pixel(input coord_t x, input coord_t y);
		int waited;
		tile_kind_t want;
		if (x < 0 || x >= BOARD_TILES * TILE_PIXELS
				|| y < 0 || y >= BOARD_TILES * TILE_PIXELS)
			want = tile_wall; // off board reads as wall
		else
			want = model_map[(int'(y) / TILE_PIXELS) * BOARD_TILES + int'(x) / TILE_PIXELS];
		@(posedge clk);
		pixel_x <= x;
		pixel_y <= y;
		@(posedge clk); // fetch notices the new tile here, stale valid drops
		@(negedge clk);
		waited = 0;
		while (!pixel_tile_valid && waited < LOOKUP_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (!pixel_tile_valid) begin
			$display("lookup at pixel (%0d,%0d) never became valid", x, y);
			errors++;
		end else begin
			check_kind("pixel_tile", pixel_tile, want);
		end
	endtask

	task automatic run_motion(input row_t rw);
		coord_t prev_y;
		bit went_up, went_down;
		coord_t tile_top;
		tile_top = coord_t'(START_ROW * TILE_PIXELS);
		prev_y = offset_topleft_y;
		went_up = 0;
		went_down = 0;
		{key_left, key_right, key_up, key_down} <= rw.keys;
		for (int f = 1; f <= rw.frames; f++) begin
			run_frame();
			if (rw.checks & CHK_Y_TILE)
				check_coord_range("offset y", offset_topleft_y, tile_top,
					tile_top + coord_t'(TILE_PIXELS - BUMPY_PIXELS));
			if (rw.checks & CHK_X_FLOOR) // one frame step past the wall at most
				check_coord_range("offset x", offset_topleft_x,
					coord_t'((START_COL * (TILE_PIXELS << FIXED_POINT_SHIFT) - SPEED)
					>>> FIXED_POINT_SHIFT), coord_t'(BOARD_TILES * TILE_PIXELS));
			if (rw.checks & CHK_FROZEN) begin // model position at death, from frame 1 on
				check_bit("dead", dead, 1'b1);
				check_coord("frozen x", offset_topleft_x, rw.exp_x);
				check_coord("frozen y", offset_topleft_y, rw.exp_y);
			end
			if (offset_topleft_y > prev_y)
				went_up = 1;
			if (offset_topleft_y < prev_y)
				went_down = 1;
			prev_y = offset_topleft_y;
		end
		@(negedge clk);
		if ((rw.checks & CHK_BOB) && !(went_up && went_down)) begin
			$display("ERR %0t: idle bob did not move both ways", $time);
			errors++;
		end
		check_coord("offset x", offset_topleft_x, rw.exp_x);
		check_coord("offset y", offset_topleft_y, rw.exp_y);
		check_bit("dead", dead, rw.exp_dead);
	endtask

	task automatic run_lookups();
		logic [31:0] rx, ry;
		lookup_pixel(-11'sd1, -11'sd1); // off board first, forces fresh reads
		for (int i = 0; i < 20; i++) begin
			rx = next_rand();
			ry = next_rand();
			lookup_pixel(coord_t'(rx % (BOARD_TILES * TILE_PIXELS)),
				coord_t'(ry % (BOARD_TILES * TILE_PIXELS)));
		end
	endtask

	// run length follows from the table
	initial begin
		longint limit_ns;
		#1;
		limit_ns = 0;
		foreach (rows[i])
			limit_ns += rows[i].frames * FRAME_CYCLES * CLK_PERIOD + ROW_MARGIN;
		#(limit_ns);
		$display("timeout: test rows still running after %0d ns", limit_ns);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int err_before;
		int asrt_fails;
		clk = 1'b0;
		resetN = 1'b0;
		start_of_frame = 1'b0;
		{key_left, key_right, key_up, key_down} = K_NONE;
		map_we = 1'b0;
		map_waddr = '0;
		map_wdata = tile_floor;
		pixel_x = '0;
		pixel_y = '0;

		add_row("reset", 0, 0, -1, tile_floor, K_NONE, 0, 0);
		add_row("left", 0, 0, -1, tile_floor, K_LEFT, 64, CHK_Y_TILE);
		add_row("idle", 0, 0, -1, tile_floor, K_NONE, 200, CHK_Y_TILE | CHK_BOB);
		add_row("left wall", 0, 0, START_ROW * BOARD_TILES + START_COL - 1, tile_wall,
			K_LEFT, 100, CHK_X_FLOOR);
		add_row("hole", 0, 0, START_ROW * BOARD_TILES + START_COL, tile_hole,
			K_NONE, 10, CHK_FROZEN);
		add_row("lookup", 1, 1, -1, tile_floor, K_NONE, 0, 0);

		foreach (rows[r]) begin
			err_before = errors;
			apply_reset();
			build_map(rows[r]);
			load_map();
			if (rows[r].lookup)
				run_lookups();
			else
				run_motion(rows[r]);
			$display("row %0d %s: %s, %0d errors", r, rows[r].name,
				(errors == err_before) ? "ok" : "failed", errors - err_before);
		end

		asrt_fails = uut.u_arb.u_chk_arb.fails + uut.u_ctrl.u_chk_ctrl.fails;
		$display("%0d rows, %0d checks, %0d errors, %0d assertion failures",
			rows.size(), checks, errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- sources.f
logic/bumpy_pkg.sv
logic/tile_map.sv
logic/map_arbiter.sv
logic/tile_probe.sv
logic/pixel_tile_fetch.sv
logic/bumpy_control.sv
logic/bumpy_move.sv
logic/bumpy_top.sv
tb/bumpy_checker.sv
tb/bumpy_tb.sv
